// File: common/vshift_cfg_pkg.sv
// Vector shifter configuration
package vshift_cfg_pkg;

  // Lane geometry

  // Number of vector lanes
  localparam int num_lanes = 4;

  // Bits per data element
  localparam int elem_w = 32;

  // Step count width
  // Must hold 0 through num_lanes inclusive
  localparam int step_w = $clog2(num_lanes + 1);

  // Element types

  // One data element as held by a lane
  typedef logic [elem_w-1:0] elem_t;

  // The mask shifter reuses the lane logic with a plain bit
  // as its payload, so it needs no separate type here.

  // Notes on encoding
  //   Lane 0 is the lowest lane
  //   A left slide moves data toward higher lane numbers
  //   A right slide moves data toward lane 0
  //   Fill words enter at the end the data moves away from

  // Limits
  //   step_w is 3 for four lanes, so counts up to 7 fit.
  //   Any count of num_lanes or more flushes every lane to fill.

  // With num_lanes = 4 and elem_w = 32 a full vector is 128 bits

endpackage

// File: common/vshift_cmd_pkg.sv
// Slide command and result formats
package vshift_cmd_pkg;

  import vshift_cfg_pkg::*;

  // Command from the lane datapath
  // One-cycle strobe qualifies it at the top level
  typedef struct packed {
    elem_t [num_lanes-1:0] data;      // Source elements, lane 0 in the low bits
    logic  [num_lanes-1:0] mask;      // 1 = lane active
    logic                  dir_left;  // 1 = toward higher lanes
    logic  [step_w-1:0]    steps;     // Positions to move
    elem_t                 fill;      // Word shifted in at the open end
  } slide_cmd_t;

  // Result back to the datapath
  // Valid only in the cycle of its strobe
  typedef struct packed {
    elem_t [num_lanes-1:0] data;  // Shifted elements
    logic  [num_lanes-1:0] mask;  // Shifted mask, 0 where fill entered
  } slide_res_t;

  // Bit budget for four 32-bit lanes
  //   command  4*32 + 4 + 1 + 3 + 32 = 168 bits
  //   result   4*32 + 4             = 132 bits

  // Squashed lanes show up as zero data with mask 0.
  // A fill word entering the vector always arrives with mask 0,
  // so the consumer can tell it apart from real data.

endpackage

// File: design/velm_laneunit.sv
// Vector lane element register
`timescale 1ns/1ps

module velm_laneunit
  import vshift_cfg_pkg::*;
#(
  parameter type elem_type = elem_t  // Payload held by this lane
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     load,        // Parallel load, wins over shift
  input  logic     shift,       // Move by one position
  input  logic     dir_left,    // 1 = take lower neighbor
  input  logic     squash,      // Clear lane on load
  input  elem_type inpipe,      // Parallel input
  input  elem_type from_left,   // Upper neighbor or chain end
  input  elem_type from_right,  // Lower neighbor or chain end
  output elem_type outpipe      // Registered lane value
);

  elem_type elem_q;     // Lane storage
  elem_type load_val;   // Value taken on load
  elem_type shift_val;  // Value taken on shift

  // Masked-off lanes enter as zero
  assign load_val = squash ? elem_type'('0) : inpipe;

  // Left slide pulls from below, right slide from above
  assign shift_val = dir_left ? from_right : from_left;

  // Update only on load or shift edges
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      elem_q <= elem_type'('0);
    end else if (load) begin
      elem_q <= load_val;       // Load first
    end else if (shift) begin
      elem_q <= shift_val;
    end
    // Otherwise hold
  end

  // One cycle after the update edge
  assign outpipe = elem_q;

endmodule

// File: design/velmshifter.sv
// Bidirectional lane chain shifter
`timescale 1ns/1ps

// Chain layout
//   shiftin_left -> lane n-1 <-> ... <-> lane 1 <-> lane 0 <- shiftin_right

module velmshifter
  import vshift_cfg_pkg::*;
#(
  parameter int  num_lanes_p = num_lanes,  // Lanes in the chain
  parameter type elem_type   = elem_t      // Payload per lane
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              load,           // Parallel load all lanes
  input  logic                              shift,          // Move every lane one step
  input  logic                              dir_left,       // 1 = toward higher lanes
  input  logic     [num_lanes_p-1:0]        squash,         // Per-lane clear on load
  input  elem_type                          shiftin_left,   // Enters the last lane
  input  elem_type                          shiftin_right,  // Enters lane 0
  input  elem_type [num_lanes_p-1:0]        inpipe,         // One slice per lane
  output elem_type [num_lanes_p-1:0]        outpipe
);

  for (genvar i = 0; i < num_lanes_p; i++) begin : g_lane
    elem_type from_left;   // Source for a right slide
    elem_type from_right;  // Source for a left slide

    // Lower end of the chain
    if (i == 0) begin : g_first
      assign from_right = shiftin_right;
    end else begin : g_lower
      assign from_right = outpipe[i-1];  // Lower neighbor
    end

    // Upper end, a single lane gets both ends
    if (i == num_lanes_p - 1) begin : g_last
      assign from_left = shiftin_left;
    end else begin : g_upper
      assign from_left = outpipe[i+1];   // Upper neighbor
    end

    velm_laneunit #(
      .elem_type (elem_type)
    ) u_lane (
      .clk        (clk),
      .arst_n     (arst_n),
      .load       (load),
      .shift      (shift),
      .dir_left   (dir_left),
      .squash     (squash[i]),
      .inpipe     (inpipe[i]),
      .from_left  (from_left),
      .from_right (from_right),
      .outpipe    (outpipe[i])
    );
  end

endmodule

// File: design/vslide_ctrl.sv
// Slide command controller
`timescale 1ns/1ps

module vslide_ctrl
  import vshift_cfg_pkg::*;
  import vshift_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cmd_valid,  // One-cycle command strobe
  input  slide_cmd_t           cmd,
  output logic                 busy,       // Operation in flight
  output logic                 load,       // Load lanes on accept edge
  output logic                 shift,      // One step per cycle
  output logic                 dir_left,   // Held direction
  output logic [num_lanes-1:0] squash,     // Clear masked lanes on load
  output elem_t                fill,       // Held fill word
  output logic                 res_valid   // One-cycle result strobe
);

  logic              busy_q;      // Set on accept, cleared after result
  logic [step_w-1:0] steps_left;  // Remaining shift steps
  logic              res_q;       // Registered completion strobe
  logic              dir_q;       // Direction of current command
  elem_t             fill_q;      // Fill word of current command
  logic              accept;      // Command taken this cycle
  logic              last_step;   // Final shift happens this cycle

  // Strobes while busy are dropped
  assign accept = cmd_valid && !busy_q;

  // Load on the accept edge itself
  assign load = accept;

  // Inactive lanes travel as zero
  assign squash = load ? ~cmd.mask : '0;

  // Shift while steps remain
  assign shift = busy_q && (steps_left != '0);

  assign last_step = shift && (steps_left == step_w'(1));

  // Control state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q     <= 1'b0;
      steps_left <= '0;
      res_q      <= 1'b0;
    end else begin
      // Result one cycle after the final update edge
      // Zero steps finish straight after the load
      res_q <= load ? (cmd.steps == '0) : last_step;

      if (load) begin
        busy_q     <= 1'b1;
        steps_left <= cmd.steps;
      end else begin
        if (shift) begin
          steps_left <= steps_left - step_w'(1);  // Count down
        end
        if (res_q) begin
          busy_q <= 1'b0;  // Busy through the result cycle
        end
      end
    end
  end

  // Direction and fill held for the whole slide
  always_ff @(posedge clk) begin
    if (accept) begin
      dir_q  <= cmd.dir_left;
      fill_q <= cmd.fill;
    end
  end

  assign busy      = busy_q;
  assign dir_left  = dir_q;
  assign fill      = fill_q;
  assign res_valid = res_q;

  // Cycle map for steps = n after accept edge 0
  //   cycles 1..n    shift high
  //   cycle n+1      res_valid high, busy still high
  //   cycle n+2      ready for the next command

endmodule

// File: design/vslide_top.sv
// Vector slide unit top level
`timescale 1ns/1ps

module vslide_top
  import vshift_cfg_pkg::*;
  import vshift_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cmd_valid,  // Command strobe
  input  slide_cmd_t cmd,
  output logic       busy,       // Commands ignored while high
  output logic       res_valid,  // Result strobe
  output slide_res_t res
);

  logic                  load;       // Parallel load both shifters
  logic                  shift;      // Step both shifters
  logic                  dir_left;
  logic [num_lanes-1:0]  squash;
  elem_t                 fill;
  elem_t [num_lanes-1:0] data_out;   // Shifted elements
  logic  [num_lanes-1:0] mask_out;   // Shifted mask bits

  vslide_ctrl u_ctrl (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .load      (load),
    .shift     (shift),
    .dir_left  (dir_left),
    .squash    (squash),
    .fill      (fill),
    .res_valid (res_valid)
  );

  // Data lanes, fill word at both ends
  velmshifter #(.num_lanes_p(num_lanes), .elem_type(elem_t)) u_data_shift (
    .clk (clk), .arst_n (arst_n), .load (load), .shift (shift),
    .dir_left (dir_left), .squash (squash),
    .shiftin_left (fill), .shiftin_right (fill),
    .inpipe (cmd.data), .outpipe (data_out)
  );

  // Mask lanes, zero enters so new lanes are inactive
  velmshifter #(.num_lanes_p(num_lanes), .elem_type(logic)) u_mask_shift (
    .clk (clk), .arst_n (arst_n), .load (load), .shift (shift),
    .dir_left (dir_left), .squash (squash),
    .shiftin_left (1'b0), .shiftin_right (1'b0),
    .inpipe (cmd.mask), .outpipe (mask_out)
  );

  // Pack lanes into the result word
  assign res.data = data_out;
  assign res.mask = mask_out;

endmodule

// File: sources.f
common/vshift_cfg_pkg.sv
common/vshift_cmd_pkg.sv
design/velm_laneunit.sv
design/velmshifter.sv
design/vslide_ctrl.sv
design/vslide_top.sv
verif/vslide_assert.sv
verif/vslide_tb.sv

// File: verif/vslide_assert.sv
// Slide controller protocol checks
`timescale 1ns/1ps

module vslide_assert (
  input logic clk,
  input logic arst_n,
  input logic busy,
  input logic load,
  input logic shift,
  input logic res_valid
);

  // Load needs idle, shift needs busy
  load_shift_excl: assert property (
    @(posedge clk) disable iff (!arst_n) !(load && shift)
  ) else $error("load and shift high in the same cycle");

  // One-cycle completion strobe
  res_single_pulse: assert property (
    @(posedge clk) disable iff (!arst_n) res_valid |=> !res_valid
  ) else $error("res_valid held for more than one cycle");

  // Result cycle still counts as busy
  res_while_busy: assert property (
    @(posedge clk) disable iff (!arst_n) res_valid |-> busy
  ) else $error("res_valid without busy");

  // Idle straight out of reset
  idle_after_reset: assert property (
    @(posedge clk) $rose(arst_n) |-> (!busy && !res_valid)
  ) else $error("controller not idle after reset release");

endmodule

bind vslide_ctrl vslide_assert u_assert (
  .clk       (clk),
  .arst_n    (arst_n),
  .busy      (busy),
  .load      (load),
  .shift     (shift),
  .res_valid (res_valid)
);

// File: verif/vslide_input.txt
// d0 d1 d2 d3 mask dir steps fill exp0 exp1 exp2 exp3 exp_mask second_strobe
// All hex, lane 0 first, mask bit i is lane i, dir 1 moves toward higher lanes
11111111 22222222 33333333 44444444 f 1 1 f0f0f0f0 f0f0f0f0 11111111 22222222 33333333 e 0
11111111 22222222 33333333 44444444 f 1 2 f0f0f0f0 f0f0f0f0 f0f0f0f0 11111111 22222222 c 0
11111111 22222222 33333333 44444444 f 1 3 f0f0f0f0 f0f0f0f0 f0f0f0f0 f0f0f0f0 11111111 8 0
11111111 22222222 33333333 44444444 f 0 1 f0f0f0f0 22222222 33333333 44444444 f0f0f0f0 7 0
11111111 22222222 33333333 44444444 f 0 2 f0f0f0f0 33333333 44444444 f0f0f0f0 f0f0f0f0 3 0
11111111 22222222 33333333 44444444 f 0 3 f0f0f0f0 44444444 f0f0f0f0 f0f0f0f0 f0f0f0f0 1 0
11111111 22222222 33333333 44444444 f 1 0 f0f0f0f0 11111111 22222222 33333333 44444444 f 0
11111111 22222222 33333333 44444444 5 0 0 f0f0f0f0 11111111 00000000 33333333 00000000 5 0
11111111 22222222 33333333 44444444 f 1 4 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0 0
11111111 22222222 33333333 44444444 f 0 4 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0f0f0f0f 0 0
11111111 22222222 33333333 44444444 5 1 1 0000ffff 0000ffff 11111111 00000000 33333333 a 0
11111111 22222222 33333333 44444444 a 0 1 0000ffff 22222222 00000000 44444444 0000ffff 5 0
11111111 22222222 33333333 44444444 6 0 2 0000ffff 33333333 00000000 0000ffff 0000ffff 1 0
11111111 22222222 33333333 44444444 9 1 2 0000ffff 0000ffff 0000ffff 11111111 00000000 4 0
aaaaaaaa bbbbbbbb cccccccc dddddddd f 1 1 5a5a5a5a 5a5a5a5a aaaaaaaa bbbbbbbb cccccccc e 1
aaaaaaaa bbbbbbbb cccccccc dddddddd f 0 3 5a5a5a5a dddddddd 5a5a5a5a 5a5a5a5a 5a5a5a5a 1 1
aaaaaaaa bbbbbbbb cccccccc dddddddd 3 0 0 5a5a5a5a aaaaaaaa bbbbbbbb 00000000 00000000 3 1
11111111 22222222 33333333 44444444 0 1 1 12345678 12345678 00000000 00000000 00000000 0 0
11111111 22222222 33333333 44444444 3 0 4 12345678 12345678 12345678 12345678 12345678 0 1
00000001 deadbeef 80000000 7fffffff d 1 3 00000000 00000000 00000000 00000000 00000001 8 0
00000001 deadbeef 80000000 7fffffff d 0 1 cafef00d 00000000 80000000 7fffffff cafef00d 6 0
00000001 deadbeef 80000000 7fffffff 0 1 0 cafef00d 00000000 00000000 00000000 00000000 0 1

// File: verif/vslide_tb.sv
// Slide unit testbench
`timescale 1ns/1ps

module vslide_tb
  import vshift_cfg_pkg::*;
  import vshift_cmd_pkg::*;
();

  localparam int timeout_cycles = 40;  // Per wait loop
  localparam int watch_cycles   = 8;   // Quiet window after a result

  logic       clk;
  logic       arst_n;
  logic       cmd_valid;
  slide_cmd_t cmd;
  logic       busy;
  logic       res_valid;
  slide_res_t res;

  int          err_count;
  int          tests_run;
  int          tests_failed;
  logic        timed_out;    // Stops the run early
  logic [31:0] lfsr_state;   // Galois LFSR, one step per bit

  vslide_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .res_valid (res_valid),
    .res       (res)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      err_count++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] val;
    int          k;
    val = '0;
    for (k = 0; k < n; k++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  // Each result lane names its source lane, or none
  function automatic slide_res_t model_slide(input slide_cmd_t c);
    slide_res_t r;
    int         st;
    int         src;
    st = int'(c.steps);
    for (int i = 0; i < num_lanes; i++) begin
      src = c.dir_left ? i - st : i + st;  // Left pulls from below
      if (src >= 0 && src < num_lanes) begin
        r.mask[i] = c.mask[src];
        r.data[i] = c.mask[src] ? c.data[src] : '0;  // Inactive source reads zero
      end else begin
        r.mask[i] = 1'b0;      // Fill is never active
        r.data[i] = c.fill;
      end
    end
    return r;
  endfunction

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < timeout_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (busy) begin
      timed_out = 1'b1;
      err_count++;
      $display("Timeout: unit stayed busy before test %0d", tests_run);
    end
  endtask

  task automatic run_test(input slide_cmd_t c, input slide_res_t exp, input logic second);
    slide_res_t  model;
    slide_cmd_t  junk;
    logic [31:0] rnd;
    logic [31:0] rsteps;
    int          cycles;
    int          extra;
    int          errs_before;
    logic        seen;
    errs_before = err_count;
    tests_run++;
    model = model_slide(c);  // File values against the model first
    for (int i = 0; i < num_lanes; i++) begin
      check_value(model.data[i], exp.data[i], $sformatf("test %0d model lane %0d", tests_run, i));
    end
    check_value(32'(model.mask), 32'(exp.mask), $sformatf("test %0d model mask", tests_run));
    wait_idle();
    if (!timed_out) begin
      cmd       = c;
      cmd_valid = 1'b1;
      cycles    = 0;
      seen      = 1'b0;
      while (!seen && cycles < timeout_cycles) begin
        @(posedge clk);  // First pass is the accept edge
        #1;
        cycles++;
        if (cycles == 1 && second) begin
          rnd           = draw_bits(32);
          rsteps        = draw_bits(2);
          junk          = c;
          junk.data     = {rnd, ~rnd, rnd ^ 32'h5555_5555, rnd + 32'd1};
          junk.mask     = rnd[3:0];
          junk.dir_left = ~c.dir_left;
          junk.steps    = step_w'(rsteps);
          junk.fill     = ~rnd;
          cmd           = junk;  // Strobe held while busy
        end else begin
          cmd_valid = 1'b0;
        end
        seen = res_valid;
        check_value(32'(busy), 1, $sformatf("test %0d busy in flight", tests_run));
      end
      if (!seen) begin
        timed_out = 1'b1;
        err_count++;
        $display("Timeout: no result for test %0d after %0d cycles", tests_run, cycles);
      end else begin
        for (int i = 0; i < num_lanes; i++) begin
          check_value(res.data[i], exp.data[i], $sformatf("test %0d lane %0d", tests_run, i));
        end
        check_value(32'(res.mask), 32'(exp.mask), $sformatf("test %0d mask", tests_run));
        check_value(cycles, int'(c.steps) + 1, $sformatf("test %0d latency", tests_run));
        extra = 0;
        for (int k = 0; k < watch_cycles; k++) begin
          @(posedge clk);
          #1;
          cmd_valid = 1'b0;
          if (res_valid) extra++;  // Ignored strobe must not answer
        end
        check_value(extra, 0, $sformatf("test %0d extra results", tests_run));
        check_value(32'(busy), 0, $sformatf("test %0d busy after result", tests_run));
      end
    end
    if (err_count != errs_before) tests_failed++;
    $display("test %0d: %s", tests_run, (err_count == errs_before) ? "ok" : "failed");
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    logic [31:0] d0, d1, d2, d3, m, dr, st, fl;
    logic [31:0] e0, e1, e2, e3, em, fg;
    slide_cmd_t  c;
    slide_res_t  e;
    clk          = 1'b0;
    arst_n       = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    lfsr_state   = 32'd9;
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    // Idle until the first command
    for (int k = 0; k < 3; k++) begin
      @(posedge clk);
      #1;
      check_value(32'(busy), 0, "busy after reset");
      check_value(32'(res_valid), 0, "res_valid after reset");
    end
    $display("reset check: %s", (err_count == 0) ? "ok" : "failed");
    fd = $fopen("verif/vslide_input.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("Could not open the stimulus file verif/vslide_input.txt");
    end else begin
      while (!$feof(fd) && !timed_out) begin
        n = $fgets(line, fd);
        if (n == 0 || line.len() < 2 || line.substr(0, 1) == "//") continue;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    d0, d1, d2, d3, m, dr, st, fl, e0, e1, e2, e3, em, fg);
        if (n != 14) begin
          err_count++;
          $display("Malformed line in stimulus file: %s", line);
        end else begin
          c.data     = {d3, d2, d1, d0};  // Lane 0 in the low bits
          c.mask     = m[num_lanes-1:0];
          c.dir_left = dr[0];
          c.steps    = st[step_w-1:0];
          c.fill     = fl;
          e.data     = {e3, e2, e1, e0};
          e.mask     = em[num_lanes-1:0];
          run_test(c, e, fg[0]);
        end
      end
      $fclose(fd);
    end
    if (tests_run == 0) begin
      err_count++;
      $display("No commands were read from the stimulus file");
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
